/* Makefile */
# Verilator build and run of the DAC I/Q channel testbench
TOOL      = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_dsp_unit
FILE_LIST = verilog.f
LOG       = sim.log
FAIL_MSG  = Done: errors found
PASS_MSG  = Done: no errors

SOURCES = $(shell grep -v '^+' $(FILE_LIST))
BIN     = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILE_LIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)

run: $(BIN) dsp_cases.txt
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* cmd_mem.sv */
// Banked command memory. The host fills each 32-bit half of a command
// separately through the bank mask; the sequencer reads the full 64-bit
// command with one clock of latency.
`timescale 1ns/1ps

module cmd_mem #(
    parameter int CMD_ADDR_WIDTH = 8
) (
    input  logic                                clk,
    input  logic [dsp_pkg::NUM_CMD_BANKS-1:0]   wr_en,
    input  logic [CMD_ADDR_WIDTH-1:0]           wr_addr,
    input  logic [dsp_pkg::HOST_DATA_WIDTH-1:0] wr_data,
    input  logic [CMD_ADDR_WIDTH-1:0]           instr_ptr,
    output logic [dsp_pkg::CMD_WIDTH-1:0]       cmd_word
);
    import dsp_pkg::*;

    localparam int DEPTH = 2 ** CMD_ADDR_WIDTH;

    logic [HOST_DATA_WIDTH-1:0] banks [NUM_CMD_BANKS][DEPTH];
    logic [NUM_CMD_BANKS-1:0][HOST_DATA_WIDTH-1:0] rd_q;  // bank 0 is the low half

    always_ff @(posedge clk) begin
        for (int b = 0; b < NUM_CMD_BANKS; b++) begin
            if (wr_en[b]) begin
                banks[b][wr_addr] <= wr_data;
            end
            rd_q[b] <= banks[b][instr_ptr];   // registered read
        end
    end

    assign cmd_word = rd_q;

    // the host decode selects one bank per write, never both halves at once
    a_one_bank: assert property (@(posedge clk) $onehot0(wr_en))
        else $error("cmd_mem: more than one bank enabled in a single write");

endmodule

/* dsp_cases.txt */
// first word: number of tests; per test: test, writes, samples, min gap
// then writes as address/data pairs, then expected samples as {Q, I}
0006
// 1: single pulse, rot 0, addresses 0..3
0001 0008 0004 0000
1000 00020001 1001 fffe7fff 1002 80001234 1003 43218000
0000 00040000 0100 10000000 0001 00000000 0101 40000000
00020001 fffe7fff 80001234 43218000
// 2: back-to-back pulses at rot 90, 180, 270 with saturation
0002 0007 000c 0000
0100 10000001 0001 00040000 0101 10000002 0002 00040000
0102 10000003 0003 00000000 0103 40000000
0001fffe 7fff0002 12347fff 8000bcdf
fffeffff 00028001 7fffedcc bcdf7fff
ffff0002 8001fffe edcc8000 7fff4321
// 3: wait of 20 cycles between two pulses
0003 0008 0004 0014
0000 00020000 0100 10000000 0001 00000014 0101 20000000
0002 00020002 0102 10000000 0003 00000000 0103 40000000
00020001 fffe7fff 80001234 43218000
// 4: jump over a pulse, then a length-0 pulse and a one-sample pulse at rot 180
0004 000c 0001 0000
1008 55555555 1009 66666666 0000 00000002 0100 30000000
0001 00020008 0101 10000000 0002 00000000 0102 10000000
0003 00010000 0103 10000002 0004 00000000 0104 40000000
fffeffff
// 5: two samples at rot 90
0005 0004 0002 0000
0000 00020000 0100 10000001 0001 00000000 0101 40000000
0001fffe 7fff0002
// 6: low bank rewritten, start address moves to 2
0006 0001 0002 0000
0000 00020002
12347fff 8000bcdf

/* dsp_pkg.sv */
// Shared widths, command field positions and enums for the DAC I/Q channel.
// Every block and the testbench import this package; command words built by
// the host must follow the field positions below.
package dsp_pkg;

    localparam int CMD_WIDTH       = 64;    // one sequencer command
    localparam int HOST_DATA_WIDTH = 32;    // host write data, also one I/Q envelope word
    localparam int HOST_ADDR_WIDTH = 13;    // bit 12 picks envelope vs command memory
    localparam int SAMPLE_WIDTH    = 16;    // one signed I or Q sample

    localparam int NUM_CMD_BANKS = CMD_WIDTH / HOST_DATA_WIDTH;  // 32-bit banks per command

    // opcode lives in the top nibble of every command
    localparam int OPC_WIDTH = 4;
    localparam int OPC_LSB   = CMD_WIDTH - OPC_WIDTH;

    // OP_PULSE fields
    localparam int ENV_FIELD_WIDTH = 10;    // start address and length
    localparam int ENV_ADDR_LSB    = 0;
    localparam int ENV_LEN_LSB     = 16;
    localparam int ROT_LSB         = 32;

    // OP_WAIT field
    localparam int WAIT_LSB   = 0;
    localparam int WAIT_WIDTH = 32;

    // OP_JUMP target sits in the low command address bits
    localparam int JUMP_LSB = 0;

    typedef enum logic [OPC_WIDTH-1:0] {
        OP_PULSE = 4'h1,
        OP_WAIT  = 4'h2,
        OP_JUMP  = 4'h3,
        OP_DONE  = 4'h4
    } opcode_t;

    // counter-clockwise quarter turns applied to each I/Q pair
    typedef enum logic [1:0] {
        ROT_0   = 2'd0,
        ROT_90  = 2'd1,
        ROT_180 = 2'd2,
        ROT_270 = 2'd3
    } rot_t;

endpackage

/* dsp_unit.sv */
// Top of one DAC I/Q channel. Decodes host writes into the command banks
// and the envelope RAM, and connects sequencer, memories and pulse element.
// Address bit 12 picks envelope (1) or command (0) memory.
`timescale 1ns/1ps

module dsp_unit #(
    parameter int CMD_ADDR_WIDTH = 8,
    parameter int ENV_ADDR_WIDTH = 10
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [dsp_pkg::HOST_ADDR_WIDTH-1:0]     mem_write_addr,
    input  logic [dsp_pkg::HOST_DATA_WIDTH-1:0]     mem_write_data,
    input  logic                                    mem_write_en,
    input  logic                                    run,
    output logic signed [dsp_pkg::SAMPLE_WIDTH-1:0] dac_i,
    output logic signed [dsp_pkg::SAMPLE_WIDTH-1:0] dac_q,
    output logic                                    dac_valid,
    output logic                                    busy,
    output logic                                    done
);
    import dsp_pkg::*;

    localparam int BANK_SEL_WIDTH = $clog2(NUM_CMD_BANKS);

    logic                       env_sel;
    logic                       env_we;
    logic [NUM_CMD_BANKS-1:0]   cmd_we;
    logic [CMD_ADDR_WIDTH-1:0]  instr_ptr;
    logic [CMD_WIDTH-1:0]       cmd_word;
    logic [ENV_ADDR_WIDTH-1:0]  env_raddr;
    logic [HOST_DATA_WIDTH-1:0] env_rdata;

    assign env_sel = mem_write_addr[HOST_ADDR_WIDTH-1];
    assign env_we  = mem_write_en & env_sel;

    // bank select sits just above the command buffer address
    always_comb begin
        for (int b = 0; b < NUM_CMD_BANKS; b++) begin
            cmd_we[b] = mem_write_en & !env_sel
                        & (mem_write_addr[CMD_ADDR_WIDTH +: BANK_SEL_WIDTH]
                           == BANK_SEL_WIDTH'(b));
        end
    end

    pulse_cmd_if #(.ENV_ADDR_WIDTH(ENV_ADDR_WIDTH)) pcmd_if ();

    cmd_mem #(.CMD_ADDR_WIDTH(CMD_ADDR_WIDTH)) cmd_mem_inst (
        .clk       (clk),
        .wr_en     (cmd_we),
        .wr_addr   (mem_write_addr[CMD_ADDR_WIDTH-1:0]),
        .wr_data   (mem_write_data),
        .instr_ptr (instr_ptr),
        .cmd_word  (cmd_word)
    );

    env_mem #(.ENV_ADDR_WIDTH(ENV_ADDR_WIDTH)) env_mem_inst (
        .clk       (clk),
        .wr_en     (env_we),
        .wr_addr   (mem_write_addr[HOST_ADDR_WIDTH-2:0]),
        .wr_data   (mem_write_data),
        .env_raddr (env_raddr),
        .env_rdata (env_rdata)
    );

    pulse_sequencer #(.CMD_ADDR_WIDTH(CMD_ADDR_WIDTH)) sequencer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .instr_ptr (instr_ptr),
        .cmd_word  (cmd_word),
        .pcmd      (pcmd_if.seq),
        .busy      (busy),
        .done      (done)
    );

    pulse_element #(.ENV_ADDR_WIDTH(ENV_ADDR_WIDTH)) element_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .pcmd      (pcmd_if.elem),
        .env_raddr (env_raddr),
        .env_rdata (env_rdata),
        .dac_i     (dac_i),
        .dac_q     (dac_q),
        .dac_valid (dac_valid)
    );

endmodule

/* env_mem.sv */
// Envelope sample RAM, one packed I/Q word per address (I low, Q high).
// The host writes it through the shared write port; the pulse element reads
// it back with one clock of latency.
`timescale 1ns/1ps

module env_mem #(
    parameter int ENV_ADDR_WIDTH = 10
) (
    input  logic                                clk,
    input  logic                                wr_en,
    input  logic [dsp_pkg::HOST_ADDR_WIDTH-2:0] wr_addr,
    input  logic [dsp_pkg::HOST_DATA_WIDTH-1:0] wr_data,
    input  logic [ENV_ADDR_WIDTH-1:0]           env_raddr,
    output logic [dsp_pkg::HOST_DATA_WIDTH-1:0] env_rdata
);
    import dsp_pkg::*;

    localparam int DEPTH = 2 ** ENV_ADDR_WIDTH;

    logic [HOST_DATA_WIDTH-1:0] samples [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            samples[wr_addr[ENV_ADDR_WIDTH-1:0]] <= wr_data;
        end
        env_rdata <= samples[env_raddr];   // old data on a same-cycle collision
    end

    // the host window is wider than the RAM, upper address bits must be zero
    a_addr_in_range: assert property (
        @(posedge clk) wr_en |-> (wr_addr >> ENV_ADDR_WIDTH) == '0
    ) else $error("env_mem: write address %0h beyond envelope depth", wr_addr);

endmodule

/* pulse_cmd_if.sv */
// Pulse command path from the sequencer to the pulse element.
// The sequencer strobes cstrobe for one cycle with the fields valid alongside;
// it may only do so while elem_busy is low.
`timescale 1ns/1ps

interface pulse_cmd_if #(
    parameter int ENV_ADDR_WIDTH = 10
);
    import dsp_pkg::*;

    logic                      cstrobe;    // one-cycle command pulse
    logic [ENV_ADDR_WIDTH-1:0] env_addr;   // first envelope word
    logic [ENV_ADDR_WIDTH-1:0] env_len;    // number of samples, 0 plays nothing
    rot_t                      rot;        // quarter-turn rotation
    logic                      elem_busy;  // element still playing

    modport seq (
        output cstrobe,
        output env_addr,
        output env_len,
        output rot,
        input  elem_busy
    );

    modport elem (
        input  cstrobe,
        input  env_addr,
        input  env_len,
        input  rot,
        output elem_busy
    );

endinterface

/* pulse_element.sv */
// Pulse element. On a strobe it plays env_len envelope words from env_addr,
// one per clock, rotates each I/Q pair by the commanded quarter turn and drives
// the DAC samples with dac_valid, two cycles after the strobe.
`timescale 1ns/1ps

module pulse_element #(
    parameter int ENV_ADDR_WIDTH = 10
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    pulse_cmd_if.elem                               pcmd,
    output logic [ENV_ADDR_WIDTH-1:0]               env_raddr,
    input  logic [dsp_pkg::HOST_DATA_WIDTH-1:0]     env_rdata,
    output logic signed [dsp_pkg::SAMPLE_WIDTH-1:0] dac_i,
    output logic signed [dsp_pkg::SAMPLE_WIDTH-1:0] dac_q,
    output logic                                    dac_valid
);
    import dsp_pkg::*;

    localparam logic signed [SAMPLE_WIDTH-1:0] SAMP_MIN = {1'b1, {(SAMPLE_WIDTH-1){1'b0}}};
    localparam logic signed [SAMPLE_WIDTH-1:0] SAMP_MAX = {1'b0, {(SAMPLE_WIDTH-1){1'b1}}};

    logic                            fetching;     // addresses still going out
    logic [ENV_ADDR_WIDTH-1:0]       rd_addr;
    logic [ENV_ADDR_WIDTH-1:0]       remaining;
    logic                            samp_valid;   // fetching delayed by the RAM latency
    rot_t                            rot_sel;
    logic signed [SAMPLE_WIDTH-1:0]  in_i;
    logic signed [SAMPLE_WIDTH-1:0]  in_q;
    logic signed [SAMPLE_WIDTH-1:0]  out_i;
    logic signed [SAMPLE_WIDTH-1:0]  out_q;

    // negate, clamping the most negative value to the positive limit
    function automatic logic signed [SAMPLE_WIDTH-1:0] sat_neg(
        input logic signed [SAMPLE_WIDTH-1:0] x
    );
        if (x == SAMP_MIN) begin
            return SAMP_MAX;
        end
        return -x;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetching   <= 1'b0;
            rd_addr    <= '0;
            remaining  <= '0;
            samp_valid <= 1'b0;
        end else begin
            samp_valid <= fetching;
            if (pcmd.cstrobe) begin
                rd_addr   <= pcmd.env_addr;
                remaining <= pcmd.env_len;
                fetching  <= (pcmd.env_len != '0);  // zero length stays idle
            end else if (fetching) begin
                rd_addr   <= rd_addr + 1'b1;
                remaining <= remaining - 1'b1;
                if (remaining == 1) begin
                    fetching <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pcmd.cstrobe) begin
            rot_sel <= pcmd.rot;
        end
    end

    assign env_raddr      = rd_addr;
    assign pcmd.elem_busy = fetching | samp_valid;   // held until the last sample is out

    assign in_i = env_rdata[SAMPLE_WIDTH-1:0];
    assign in_q = env_rdata[2*SAMPLE_WIDTH-1:SAMPLE_WIDTH];

    always_comb begin
        case (rot_sel)
            ROT_0: begin
                out_i = in_i;
                out_q = in_q;
            end
            ROT_90: begin
                out_i = sat_neg(in_q);
                out_q = in_i;
            end
            ROT_180: begin
                out_i = sat_neg(in_i);
                out_q = sat_neg(in_q);
            end
            default: begin   // ROT_270
                out_i = in_q;
                out_q = sat_neg(in_i);
            end
        endcase
    end

    assign dac_valid = samp_valid;
    assign dac_i     = samp_valid ? out_i : '0;
    assign dac_q     = samp_valid ? out_q : '0;

    a_strobe_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n) pcmd.cstrobe |-> !fetching && !samp_valid
    ) else $error("pulse_element: strobe arrived during playback");

endmodule

/* pulse_sequencer.sv */
// Command sequencer FSM. A run pulse restarts it at address 0; it then fetches
// and decodes one command every two cycles, issuing pulses to the element,
// counting waits, following jumps and stopping on OP_DONE.
`timescale 1ns/1ps

module pulse_sequencer #(
    parameter int CMD_ADDR_WIDTH = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          run,
    output logic [CMD_ADDR_WIDTH-1:0]     instr_ptr,
    input  logic [dsp_pkg::CMD_WIDTH-1:0] cmd_word,
    pulse_cmd_if.seq                      pcmd,
    output logic                          busy,
    output logic                          done
);
    import dsp_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,     // address out, memory read in flight
        S_DECODE,    // cmd_word valid
        S_WAIT,
        S_STALL,     // pulse held until the element is free
        S_DONE
    } state_t;

    state_t                state;
    opcode_t               opcode;
    logic [WAIT_WIDTH-1:0] wait_cnt;
    logic                  issue;

    assign opcode = opcode_t'(cmd_word[OPC_LSB +: OPC_WIDTH]);

    // a pulse leaves from decode or stall, only once the element is idle
    assign issue = ((state == S_DECODE && opcode == OP_PULSE) || state == S_STALL)
                   && !pcmd.elem_busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= S_IDLE;
            instr_ptr    <= '0;
            wait_cnt     <= '0;
            busy         <= 1'b0;
            done         <= 1'b0;
            pcmd.cstrobe <= 1'b0;
        end else begin
            pcmd.cstrobe <= issue;
            case (state)
                S_IDLE, S_DONE: begin
                    if (run) begin
                        state     <= S_FETCH;
                        instr_ptr <= '0;
                        busy      <= 1'b1;
                        done      <= 1'b0;
                    end
                end
                S_FETCH: state <= S_DECODE;
                S_DECODE: begin
                    case (opcode)
                        OP_PULSE: begin
                            if (issue) begin
                                instr_ptr <= instr_ptr + 1'b1;
                                state     <= S_FETCH;
                            end else begin
                                state <= S_STALL;
                            end
                        end
                        OP_WAIT: begin
                            instr_ptr <= instr_ptr + 1'b1;
                            wait_cnt  <= cmd_word[WAIT_LSB +: WAIT_WIDTH];
                            if (cmd_word[WAIT_LSB +: WAIT_WIDTH] == '0) begin
                                state <= S_FETCH;
                            end else begin
                                state <= S_WAIT;
                            end
                        end
                        OP_JUMP: begin
                            instr_ptr <= cmd_word[JUMP_LSB +: CMD_ADDR_WIDTH];
                            state     <= S_FETCH;
                        end
                        default: begin   // OP_DONE and anything unknown
                            busy  <= 1'b0;
                            done  <= 1'b1;
                            state <= S_DONE;
                        end
                    endcase
                end
                S_WAIT: begin
                    // count only once the previous pulse has finished playing
                    if (!pcmd.elem_busy) begin
                        wait_cnt <= wait_cnt - 1'b1;
                        if (wait_cnt == 1) begin
                            state <= S_FETCH;
                        end
                    end
                end
                S_STALL: begin
                    if (issue) begin
                        instr_ptr <= instr_ptr + 1'b1;
                        state     <= S_FETCH;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // pulse fields go out together with the strobe
    always_ff @(posedge clk) begin
        if (issue) begin
            pcmd.env_addr <= cmd_word[ENV_ADDR_LSB +: ENV_FIELD_WIDTH];
            pcmd.env_len  <= cmd_word[ENV_LEN_LSB +: ENV_FIELD_WIDTH];
            pcmd.rot      <= rot_t'(cmd_word[ROT_LSB +: $bits(rot_t)]);
        end
    end

    // the element must still be idle when the registered strobe arrives
    a_no_strobe_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        pcmd.cstrobe |-> !pcmd.elem_busy
    ) else $error("pulse_sequencer: cstrobe issued while element busy");

endmodule

/* tb_dsp_unit.sv */
// Self-checking testbench for the DAC I/Q channel. Each test in dsp_cases.txt
// loads commands and envelope words through the host port, pulses run and
// compares the collected {Q, I} stream with the expected samples.
`timescale 1ns/1ps

module tb_dsp_unit;
    import dsp_pkg::*;

    localparam int CASE_WORDS = 256;

    logic                           clk = 1'b0;
    logic                           rst_n;
    logic [HOST_ADDR_WIDTH-1:0]     mem_write_addr;
    logic [HOST_DATA_WIDTH-1:0]     mem_write_data;
    logic                           mem_write_en;
    logic                           run;
    logic signed [SAMPLE_WIDTH-1:0] dac_i;
    logic signed [SAMPLE_WIDTH-1:0] dac_q;
    logic                           dac_valid;
    logic                           busy;
    logic                           done;

    logic [31:0] cases_mem [CASE_WORDS];
    logic [31:0] got_q [$];                 // {Q, I} as seen on the DAC port
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;
    int          cur_test    = 0;
    int          errors      = 0;
    int          checks      = 0;
    int          max_gap;                   // longest idle stretch between two samples
    int          stream_errs;               // busy/done mismatches seen while collecting

    always #20 clk = ~clk;

    dsp_unit dsp_unit_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_write_addr (mem_write_addr),
        .mem_write_data (mem_write_data),
        .mem_write_en   (mem_write_en),
        .run            (run),
        .dac_i          (dac_i),
        .dac_q          (dac_q),
        .dac_valid      (dac_valid),
        .busy           (busy),
        .done           (done)
    );

    // watchdog limit comes from the case file before the first edge
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("test %0d: done never rose within the limit of %0d cycles",
                     cur_test, cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic host_write(input logic [HOST_ADDR_WIDTH-1:0] addr,
                              input logic [HOST_DATA_WIDTH-1:0] data);
        @(posedge clk);
        mem_write_addr <= addr;
        mem_write_data <= data;
        mem_write_en   <= 1'b1;
    endtask

    task automatic start_run;
        @(posedge clk);
        mem_write_en <= 1'b0;
        run          <= 1'b1;
        @(posedge clk);
        run          <= 1'b0;
    endtask

    // gather samples until done has been seen and the DAC has gone quiet
    task automatic collect_stream;
        int idle;
        int quiet;
        bit seen_first;
        bit seen_done;
        idle        = 0;
        quiet       = 0;
        seen_first  = 1'b0;
        seen_done   = 1'b0;
        max_gap     = 0;
        stream_errs = 0;
        got_q.delete();
        while (!(seen_done && quiet >= 3)) begin
            @(negedge clk);
            // busy covers the whole run and drops as done rises
            assert (busy == !done) else begin
                $display("[ERROR] %0t test %0d: busy %b with done %b",
                         $time, cur_test, busy, done);
                stream_errs++;
            end
            if (dac_valid) begin
                got_q.push_back({dac_q, dac_i});
                if (seen_first && idle > max_gap) begin
                    max_gap = idle;
                end
                seen_first = 1'b1;
                idle       = 0;
                quiet      = 0;
            end else begin
                idle++;
                quiet++;
            end
            if (done && !seen_done) begin
                seen_done = 1'b1;
                quiet     = 0;       // last pulse may still be playing
            end
        end
    endtask

    initial begin
        int          ptr;
        int          n_tests;
        int          n_wr;
        int          n_smp;
        int          min_gap;
        int          test_errs;
        logic [31:0] exp_word;
        rst_n          = 1'b0;
        mem_write_addr = '0;
        mem_write_data = '0;
        mem_write_en   = 1'b0;
        run            = 1'b0;
        $readmemh("dsp_cases.txt", cases_mem);
        n_tests = int'(cases_mem[0]);
        ptr     = 1;
        for (int t = 0; t < n_tests; t++) begin
            cycle_limit += 4 * (int'(cases_mem[ptr+2]) + int'(cases_mem[ptr+3]) + 50);
            ptr += 4 + 2 * int'(cases_mem[ptr+1]) + int'(cases_mem[ptr+2]);
        end

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        ptr = 1;
        for (int t = 0; t < n_tests; t++) begin
            cur_test  = int'(cases_mem[ptr]);
            n_wr      = int'(cases_mem[ptr+1]);
            n_smp     = int'(cases_mem[ptr+2]);
            min_gap   = int'(cases_mem[ptr+3]);
            test_errs = 0;
            ptr += 4;
            for (int w = 0; w < n_wr; w++) begin
                host_write(cases_mem[ptr][HOST_ADDR_WIDTH-1:0], cases_mem[ptr+1]);
                ptr += 2;
            end
            start_run();
            collect_stream();
            checks++;
            test_errs += stream_errs;

            checks++;
            assert (got_q.size() == n_smp) else begin
                $display("test %0d: expected %0d samples but received %0d",
                         cur_test, n_smp, got_q.size());
                test_errs++;
            end
            for (int i = 0; i < n_smp && i < got_q.size(); i++) begin
                exp_word = cases_mem[ptr+i];
                checks++;
                assert (got_q[i] == exp_word) else begin
                    $display("[ERROR] %0t test %0d sample %0d: got %h, expected %h",
                             $time, cur_test, i, got_q[i], exp_word);
                    test_errs++;
                end
            end
            ptr += n_smp;
            if (min_gap > 0) begin
                checks++;
                assert (max_gap >= min_gap) else begin
                    $display("[ERROR] %0t test %0d: longest gap %0d cycles, need %0d",
                             $time, cur_test, max_gap, min_gap);
                    test_errs++;
                end
            end
            errors += test_errs;
            $display("test %0d: %0d samples, %0d errors", cur_test, got_q.size(), test_errs);
        end

        $display("tests: %0d, checks: %0d, errors: %0d", n_tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* verilog.f */
dsp_pkg.sv
pulse_cmd_if.sv
cmd_mem.sv
env_mem.sv
pulse_sequencer.sv
pulse_element.sv
dsp_unit.sv
tb_dsp_unit.sv
